// ==== verilog/isaPkg.sv ====
`default_nettype none

package isaPkg;

    localparam int wordWidth = 32;
    localparam int regAddrWidth = 5;

    // Primary opcodes
    localparam logic [5:0] opRtype = 6'h00;
    localparam logic [5:0] opJ = 6'h02;
    localparam logic [5:0] opBeq = 6'h04;
    localparam logic [5:0] opBne = 6'h05;
    localparam logic [5:0] opAddiu = 6'h09;
    localparam logic [5:0] opOri = 6'h0d;
    localparam logic [5:0] opLui = 6'h0f;
    localparam logic [5:0] opLw = 6'h23;
    localparam logic [5:0] opSw = 6'h2b;

    // R-type function field
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd = 6'h24;
    localparam logic [5:0] fnOr = 6'h25;
    localparam logic [5:0] fnSlt = 6'h2a;

    typedef struct packed {
        logic [5:0] opcode;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        logic [regAddrWidth-1:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } regFormat;

    // Jump index is {rs, rt, imm16} of this view
    typedef struct packed {
        logic [5:0] opcode;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        logic [15:0] imm16;
    } immFormat;

    typedef union packed {
        regFormat r;
        immFormat i;
    } instrWord;

endpackage

`default_nettype wire

// ==== verilog/pipePkg.sv ====
`default_nettype none

package pipePkg;

    // ALU operations
    localparam logic [2:0] aluAdd = 3'd0;
    localparam logic [2:0] aluSub = 3'd1;
    localparam logic [2:0] aluAnd = 3'd2;
    localparam logic [2:0] aluOr = 3'd3;
    localparam logic [2:0] aluSlt = 3'd4;
    localparam logic [2:0] aluLui = 3'd5;

    // Where the register write value comes from
    localparam logic [1:0] wbNone = 2'd0;
    localparam logic [1:0] wbAlu = 2'd1;
    localparam logic [1:0] wbLink = 2'd2;
    localparam logic [1:0] wbMem = 2'd3;

    localparam logic [isaPkg::wordWidth-1:0] resetVector = 32'hBFC00000;
    localparam logic [isaPkg::wordWidth-1:0] instrStep = 32'd4;

    localparam logic [2:0] dataSizeWord = 3'd2;
    localparam logic [3:0] wordByteEnable = 4'b1111;

endpackage

`default_nettype wire

// ==== verilog/instructionDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instructionDecoder (
    input isaPkg::instrWord instr,
    output logic [isaPkg::regAddrWidth-1:0] srcA,
    output logic [isaPkg::regAddrWidth-1:0] srcB,
    output logic useA,
    output logic useB,
    output logic [isaPkg::regAddrWidth-1:0] dest,
    output logic [2:0] aluOp,
    output logic useImm,
    output logic signExt,
    output logic isLoad,
    output logic isStore,
    output logic isBranch,
    output logic branchOnEqual,
    output logic isJump,
    output logic [isaPkg::wordWidth-1:0] imm,
    output logic [1:0] wbSource
);

    assign srcA = instr.r.rs;
    assign srcB = instr.r.rt;
    assign imm = signExt ? {{16{instr.i.imm16[15]}}, instr.i.imm16} : {16'b0, instr.i.imm16};

    always_comb begin
        useA = 1'b0;
        useB = 1'b0;
        dest = '0;
        aluOp = pipePkg::aluAdd;
        useImm = 1'b0;
        signExt = 1'b1;
        isLoad = 1'b0;
        isStore = 1'b0;
        isBranch = 1'b0;
        branchOnEqual = 1'b0;
        isJump = 1'b0;
        wbSource = pipePkg::wbNone;
        case (instr.r.opcode)
            isaPkg::opRtype: begin
                useA = 1'b1;
                useB = 1'b1;
                dest = instr.r.rd;
                wbSource = pipePkg::wbAlu;
                case (instr.r.funct)
                    isaPkg::fnAddu: aluOp = pipePkg::aluAdd;
                    isaPkg::fnSubu: aluOp = pipePkg::aluSub;
                    isaPkg::fnAnd: aluOp = pipePkg::aluAnd;
                    isaPkg::fnOr: aluOp = pipePkg::aluOr;
                    isaPkg::fnSlt: aluOp = pipePkg::aluSlt;
                    default: begin
                        // Unknown function, behaves as a no-op
                        useA = 1'b0;
                        useB = 1'b0;
                        dest = '0;
                        wbSource = pipePkg::wbNone;
                    end
                endcase
            end
            isaPkg::opAddiu: begin
                useA = 1'b1;
                useImm = 1'b1;
                dest = instr.i.rt;
                wbSource = pipePkg::wbAlu;
            end
            isaPkg::opOri: begin
                useA = 1'b1;
                useImm = 1'b1;
                signExt = 1'b0;
                aluOp = pipePkg::aluOr;
                dest = instr.i.rt;
                wbSource = pipePkg::wbAlu;
            end
            isaPkg::opLui: begin
                useImm = 1'b1;
                signExt = 1'b0;
                aluOp = pipePkg::aluLui;
                dest = instr.i.rt;
                wbSource = pipePkg::wbAlu;
            end
            isaPkg::opLw: begin
                useA = 1'b1;
                useImm = 1'b1;
                isLoad = 1'b1;
                dest = instr.i.rt;
                wbSource = pipePkg::wbMem;
            end
            isaPkg::opSw: begin
                useA = 1'b1;
                useB = 1'b1;
                useImm = 1'b1;
                isStore = 1'b1;
            end
            isaPkg::opBeq: begin
                useA = 1'b1;
                useB = 1'b1;
                isBranch = 1'b1;
                branchOnEqual = 1'b1;
            end
            isaPkg::opBne: begin
                useA = 1'b1;
                useB = 1'b1;
                isBranch = 1'b1;
            end
            isaPkg::opJ: isJump = 1'b1;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/registerFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module registerFile (
    input logic clk,
    input logic reset,
    input logic [isaPkg::regAddrWidth-1:0] readAddrA,
    input logic [isaPkg::regAddrWidth-1:0] readAddrB,
    output logic [isaPkg::wordWidth-1:0] readDataA,
    output logic [isaPkg::wordWidth-1:0] readDataB,
    input logic [isaPkg::regAddrWidth-1:0] writeAddr,
    input logic [isaPkg::wordWidth-1:0] writeData
);

    logic [isaPkg::wordWidth-1:0] regs [1:31];

    // Register zero reads as zero
    assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
    assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/operandForward.sv ====
`timescale 1ns/1ps
`default_nettype none

module operandForward (
    input logic [isaPkg::regAddrWidth-1:0] request,
    input logic used,
    input logic [isaPkg::wordWidth-1:0] regValue,
    input logic [isaPkg::regAddrWidth-1:0] exDest,
    input logic [isaPkg::wordWidth-1:0] exValue,
    input logic exAvail,
    input logic [isaPkg::regAddrWidth-1:0] memDest,
    input logic [isaPkg::wordWidth-1:0] memValue,
    input logic memAvail,
    input logic [isaPkg::regAddrWidth-1:0] wbDest,
    input logic [isaPkg::wordWidth-1:0] wbValue,
    output logic [isaPkg::wordWidth-1:0] value,
    output logic waiting
);

    // Youngest matching stage wins
    always_comb begin
        value = regValue;
        waiting = 1'b0;
        if (request != '0) begin
            if (request == exDest) begin
                value = exValue;
                waiting = used && !exAvail;
            end else if (request == memDest) begin
                value = memValue;
                waiting = used && !memAvail;
            end else if (request == wbDest) begin
                value = wbValue;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/fetchUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetchUnit (
    input logic clk,
    input logic reset,
    input logic hold,
    input logic redirect,
    input logic [isaPkg::wordWidth-1:0] target,
    output logic [isaPkg::wordWidth-1:0] instAddr,
    output logic instRead,
    input logic [isaPkg::wordWidth-1:0] instData,
    input logic instValid,
    output logic [isaPkg::wordWidth-1:0] fetchedInstr,
    output logic [isaPkg::wordWidth-1:0] fetchedPc,
    output logic fetchedValid
);

    logic running;
    logic bufValid;
    logic redirectPending;
    logic [isaPkg::wordWidth-1:0] pc;
    logic [isaPkg::wordWidth-1:0] bufInstr;
    logic [isaPkg::wordWidth-1:0] pendingTarget;
    logic arrived;
    logic accept;

    // pc stays on the word until decode takes it
    assign instRead = running && !bufValid;
    assign instAddr = pc;
    assign arrived = instRead && instValid;
    assign fetchedValid = bufValid || arrived;
    assign fetchedInstr = bufValid ? bufInstr : instData;
    assign fetchedPc = pc;
    assign accept = fetchedValid && !hold;

    always_ff @(posedge clk) begin
        if (reset) begin
            running <= 1'b0;
            pc <= pipePkg::resetVector;
            bufValid <= 1'b0;
            redirectPending <= 1'b0;
        end else begin
            running <= 1'b1;
            if (accept) begin
                bufValid <= 1'b0;
                redirectPending <= 1'b0;
                if (redirect) begin
                    pc <= target;
                end else if (redirectPending) begin
                    pc <= pendingTarget;
                end else begin
                    pc <= pc + pipePkg::instrStep;
                end
            end else begin
                if (arrived) begin
                    bufValid <= 1'b1;
                end
                // Delay slot still on its way, jump after it
                if (redirect) begin
                    redirectPending <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (arrived && !accept) begin
            bufInstr <= instData;
        end
        if (redirect) begin
            pendingTarget <= target;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/pipelineCpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipelineCpu (
    input logic clk,
    input logic reset,

    output logic [isaPkg::wordWidth-1:0] instAddr,
    output logic instRead,
    input logic [isaPkg::wordWidth-1:0] instData,
    input logic instValid,

    output logic [isaPkg::wordWidth-1:0] dataAddr,
    output logic dataRead,
    output logic dataWrite,
    output logic [isaPkg::wordWidth-1:0] dataWdata,
    output logic [2:0] dataSize,
    input logic [isaPkg::wordWidth-1:0] dataRdata,
    input logic dataValid,

    output logic [isaPkg::wordWidth-1:0] debugWbPc,
    output logic [3:0] debugWbRfWen,
    output logic [isaPkg::regAddrWidth-1:0] debugWbRfWnum,
    output logic [isaPkg::wordWidth-1:0] debugWbRfWdata
);

    localparam int W = isaPkg::wordWidth;
    localparam int R = isaPkg::regAddrWidth;

    logic memWaiting;
    logic decWaiting;
    logic holdFront;

    // Fetch
    logic redirect;
    logic [W-1:0] redirectTarget;
    logic [W-1:0] fetchedInstr;
    logic [W-1:0] fetchedPc;
    logic fetchedValid;

    // Decode
    logic decValid;
    isaPkg::instrWord decInstr;
    logic [W-1:0] decPc;
    logic [R-1:0] decSrcA;
    logic [R-1:0] decSrcB;
    logic decUseA;
    logic decUseB;
    logic [R-1:0] decDest;
    logic [2:0] decAluOp;
    logic decUseImm;
    logic decIsLoad;
    logic decIsStore;
    logic decIsBranch;
    logic decBranchOnEqual;
    logic decIsJump;
    logic [W-1:0] decImm;
    logic [1:0] decWbSource;
    logic [W-1:0] rfDataA;
    logic [W-1:0] rfDataB;
    logic [W-1:0] decValueA;
    logic [W-1:0] decValueB;
    logic waitA;
    logic waitB;
    logic decGo;
    logic branchTaken;
    logic [W-1:0] delaySlotPc;

    // Execute
    logic exValid;
    logic [W-1:0] exPc;
    logic [R-1:0] exDest;
    logic [2:0] exAluOp;
    logic exUseImm;
    logic exIsLoad;
    logic exIsStore;
    logic [1:0] exWbSource;
    logic [W-1:0] exA;
    logic [W-1:0] exB;
    logic [W-1:0] exImm;
    logic [W-1:0] aluB;
    logic [W-1:0] exResult;
    logic [R-1:0] exWriteReg;

    // Memory
    logic memValid;
    logic [W-1:0] memPc;
    logic [R-1:0] memDest;
    logic memIsLoad;
    logic memIsStore;
    logic [1:0] memWbSource;
    logic [W-1:0] memResult;
    logic [W-1:0] memStoreData;
    logic [W-1:0] memValue;
    logic memAvail;
    logic [R-1:0] memWriteReg;

    // Writeback
    logic wbValid;
    logic [W-1:0] wbPc;
    logic [R-1:0] wbDest;
    logic [1:0] wbWbSource;
    logic [W-1:0] wbResult;
    logic [W-1:0] wbMemData;
    logic [W-1:0] wbData;
    logic [R-1:0] wbWriteReg;

    // Memory wait outranks the decode operand wait
    assign holdFront = decWaiting || memWaiting;

    fetchUnit fetch (
        .clk(clk),
        .reset(reset),
        .hold(holdFront),
        .redirect(redirect),
        .target(redirectTarget),
        .instAddr(instAddr),
        .instRead(instRead),
        .instData(instData),
        .instValid(instValid),
        .fetchedInstr(fetchedInstr),
        .fetchedPc(fetchedPc),
        .fetchedValid(fetchedValid)
    );

    // Bubble bits for every stage
    always_ff @(posedge clk) begin
        if (reset) begin
            decValid <= 1'b0;
            exValid <= 1'b0;
            memValid <= 1'b0;
            wbValid <= 1'b0;
        end else begin
            if (!holdFront) begin
                decValid <= fetchedValid;
            end
            if (!memWaiting) begin
                exValid <= decGo;
                memValid <= exValid;
            end
            wbValid <= memValid && !memWaiting;
        end
    end

    always_ff @(posedge clk) begin
        if (!holdFront) begin
            decInstr <= fetchedInstr;
            decPc <= fetchedPc;
        end
    end

    instructionDecoder decoder (
        .instr(decInstr),
        .srcA(decSrcA),
        .srcB(decSrcB),
        .useA(decUseA),
        .useB(decUseB),
        .dest(decDest),
        .aluOp(decAluOp),
        .useImm(decUseImm),
        .signExt(),
        .isLoad(decIsLoad),
        .isStore(decIsStore),
        .isBranch(decIsBranch),
        .branchOnEqual(decBranchOnEqual),
        .isJump(decIsJump),
        .imm(decImm),
        .wbSource(decWbSource)
    );

    registerFile regFile (
        .clk(clk),
        .reset(reset),
        .readAddrA(decSrcA),
        .readAddrB(decSrcB),
        .readDataA(rfDataA),
        .readDataB(rfDataB),
        .writeAddr(wbWriteReg),
        .writeData(wbData)
    );

    operandForward forwardA (
        .request(decSrcA),
        .used(decValid && decUseA),
        .regValue(rfDataA),
        .exDest(exWriteReg),
        .exValue(exResult),
        .exAvail(1'b0),
        .memDest(memWriteReg),
        .memValue(memValue),
        .memAvail(memAvail),
        .wbDest(wbWriteReg),
        .wbValue(wbData),
        .value(decValueA),
        .waiting(waitA)
    );

    operandForward forwardB (
        .request(decSrcB),
        .used(decValid && decUseB),
        .regValue(rfDataB),
        .exDest(exWriteReg),
        .exValue(exResult),
        .exAvail(1'b0),
        .memDest(memWriteReg),
        .memValue(memValue),
        .memAvail(memAvail),
        .wbDest(wbWriteReg),
        .wbValue(wbData),
        .value(decValueB),
        .waiting(waitB)
    );

    assign decWaiting = waitA || waitB;
    assign decGo = decValid && !decWaiting;

    // Branch decision in decode, delay slot follows
    assign branchTaken = decIsBranch && ((decValueA == decValueB) == decBranchOnEqual);
    assign delaySlotPc = decPc + pipePkg::instrStep;
    assign redirect = decGo && !memWaiting && (branchTaken || decIsJump);
    assign redirectTarget = decIsJump
        ? {delaySlotPc[W-1:28], decInstr.i.rs, decInstr.i.rt, decInstr.i.imm16, 2'b00}
        : delaySlotPc + {decImm[W-3:0], 2'b00};

    always_ff @(posedge clk) begin
        if (!memWaiting) begin
            exPc <= decPc;
            exDest <= decDest;
            exAluOp <= decAluOp;
            exUseImm <= decUseImm;
            exIsLoad <= decIsLoad;
            exIsStore <= decIsStore;
            exWbSource <= decWbSource;
            exA <= decValueA;
            exB <= decValueB;
            exImm <= decImm;
        end
    end

    assign aluB = exUseImm ? exImm : exB;
    assign exWriteReg = exValid ? exDest : '0;

    always_comb begin
        case (exAluOp)
            pipePkg::aluSub: exResult = exA - aluB;
            pipePkg::aluAnd: exResult = exA & aluB;
            pipePkg::aluOr: exResult = exA | aluB;
            pipePkg::aluSlt: exResult = {{(W - 1){1'b0}}, $signed(exA) < $signed(aluB)};
            pipePkg::aluLui: exResult = {aluB[15:0], 16'b0};
            default: exResult = exA + aluB;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!memWaiting) begin
            memPc <= exPc;
            memDest <= exDest;
            memIsLoad <= exIsLoad;
            memIsStore <= exIsStore;
            memWbSource <= exWbSource;
            memResult <= exResult;
            memStoreData <= exB;
        end
    end

    // Data SRAM request holds until acknowledged
    assign dataRead = memValid && memIsLoad;
    assign dataWrite = memValid && memIsStore;
    assign dataAddr = memResult;
    assign dataWdata = memStoreData;
    assign dataSize = pipePkg::dataSizeWord;
    assign memWaiting = (dataRead || dataWrite) && !dataValid;

    assign memWriteReg = memValid ? memDest : '0;
    assign memAvail = memWbSource != pipePkg::wbMem;
    assign memValue = (memWbSource == pipePkg::wbLink)
        ? memPc + (pipePkg::instrStep << 1)
        : memResult;

    always_ff @(posedge clk) begin
        wbPc <= memPc;
        wbDest <= memDest;
        wbWbSource <= memWbSource;
        wbResult <= memValue;
        wbMemData <= dataRdata;
    end

    assign wbWriteReg = wbValid ? wbDest : '0;
    assign wbData = (wbWbSource == pipePkg::wbMem) ? wbMemData : wbResult;

    assign debugWbPc = wbPc;
    assign debugWbRfWen = (wbWriteReg != '0) ? pipePkg::wordByteEnable : 4'b0000;
    assign debugWbRfWnum = wbWriteReg;
    assign debugWbRfWdata = wbData;

endmodule

`default_nettype wire

// ==== test/memoryModel.sv ====
`timescale 1ns/1ps
`default_nettype none

module memoryModel (
    input logic clk,
    input logic [isaPkg::wordWidth-1:0] instAddr,
    input logic instRead,
    output logic [isaPkg::wordWidth-1:0] instData,
    output logic instValid,
    input logic [isaPkg::wordWidth-1:0] dataAddr,
    input logic dataRead,
    input logic dataWrite,
    input logic [isaPkg::wordWidth-1:0] dataWdata,
    output logic [isaPkg::wordWidth-1:0] dataRdata,
    output logic dataValid
);

    localparam int memWords = 256;

    logic [isaPkg::wordWidth-1:0] imem [0:memWords-1];
    logic [isaPkg::wordWidth-1:0] dmem [0:memWords-1];
    integer seed;
    integer instDelay;
    integer dataDelay;

    initial begin
        seed = 88;
        instDelay = 0;
        dataDelay = 0;
        instData = '0;
        instValid = 1'b0;
        dataRdata = '0;
        dataValid = 1'b0;
    end

    // Acknowledge after 0 to 3 extra cycles, new delay drawn per access
    always @(negedge clk) begin
        instValid = 1'b0;
        if (instRead === 1'b1) begin
            if (instDelay == 0) begin
                instValid = 1'b1;
                instData = imem[instAddr[9:2]];
                instDelay = $unsigned($random(seed)) % 4;
            end else begin
                instDelay = instDelay - 1;
            end
        end
        dataValid = 1'b0;
        if (dataRead === 1'b1 || dataWrite === 1'b1) begin
            if (dataDelay == 0) begin
                dataValid = 1'b1;
                if (dataWrite === 1'b1) begin
                    dmem[dataAddr[9:2]] = dataWdata;
                end else begin
                    dataRdata = dmem[dataAddr[9:2]];
                end
                dataDelay = $unsigned($random(seed)) % 4;
            end else begin
                dataDelay = dataDelay - 1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== test/cpuTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuTb;

    localparam int W = isaPkg::wordWidth;
    localparam int timeoutCycles = 200;
    // SRAM size code of a full word
    localparam logic [2:0] wordSizeCode = 3'd2;

    logic clk;
    logic reset;
    logic [W-1:0] instAddr;
    logic instRead;
    logic [W-1:0] instData;
    logic instValid;
    logic [W-1:0] dataAddr;
    logic dataRead;
    logic dataWrite;
    logic [W-1:0] dataWdata;
    logic [2:0] dataSize;
    logic [W-1:0] dataRdata;
    logic dataValid;
    logic [W-1:0] debugWbPc;
    logic [3:0] debugWbRfWen;
    logic [4:0] debugWbRfWnum;
    logic [W-1:0] debugWbRfWdata;

    integer errorCount;
    integer checkCount;
    integer progLen;
    logic [W-1:0] model [0:31];
    logic [W-1:0] dataModel [0:255];
    logic [4:0] expRegs [$];
    logic [W-1:0] expVals [$];
    logic [W-1:0] expPcs [$];
    logic [W-1:0] storedAddrs [$];

    pipelineCpu uut (
        .clk(clk),
        .reset(reset),
        .instAddr(instAddr),
        .instRead(instRead),
        .instData(instData),
        .instValid(instValid),
        .dataAddr(dataAddr),
        .dataRead(dataRead),
        .dataWrite(dataWrite),
        .dataWdata(dataWdata),
        .dataSize(dataSize),
        .dataRdata(dataRdata),
        .dataValid(dataValid),
        .debugWbPc(debugWbPc),
        .debugWbRfWen(debugWbRfWen),
        .debugWbRfWnum(debugWbRfWnum),
        .debugWbRfWdata(debugWbRfWdata)
    );

    memoryModel mem (
        .clk(clk),
        .instAddr(instAddr),
        .instRead(instRead),
        .instData(instData),
        .instValid(instValid),
        .dataAddr(dataAddr),
        .dataRead(dataRead),
        .dataWrite(dataWrite),
        .dataWdata(dataWdata),
        .dataRdata(dataRdata),
        .dataValid(dataValid)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    function automatic logic [W-1:0] rFormat(input logic [5:0] funct, input logic [4:0] rd,
                                             input logic [4:0] rs, input logic [4:0] rt);
        isaPkg::instrWord w;
        w.r.opcode = isaPkg::opRtype;
        w.r.rs = rs;
        w.r.rt = rt;
        w.r.rd = rd;
        w.r.shamt = '0;
        w.r.funct = funct;
        return w;
    endfunction

    // Arguments follow the encoding order of opcode, rs, rt and imm16
    function automatic logic [W-1:0] iFormat(input logic [5:0] op, input logic [4:0] rs,
                                             input logic [4:0] rt, input logic [15:0] imm);
        isaPkg::instrWord w;
        w.i.opcode = op;
        w.i.rs = rs;
        w.i.rt = rt;
        w.i.imm16 = imm;
        return w;
    endfunction

    function automatic logic [W-1:0] jumpWord(input logic [W-1:0] target);
        isaPkg::instrWord w;
        w.i.opcode = isaPkg::opJ;
        {w.i.rs, w.i.rt, w.i.imm16} = target[27:2];
        return w;
    endfunction

    function automatic logic [W-1:0] pcOf(input integer index);
        return pipePkg::resetVector + pipePkg::instrStep * index;
    endfunction

    task automatic checkValue(input string name, input string what,
                              input logic [W-1:0] expected, input logic [W-1:0] actual);
        checkCount++;
        assert (actual === expected) else begin
            $display("mismatch %s %s: expected %h, actual %h", name, what, expected, actual);
            errorCount++;
        end
    endtask

    // Every data access is a full word
    always @(negedge clk) begin
        if (dataRead === 1'b1 || dataWrite === 1'b1) begin
            checkValue("data access", "size", wordSizeCode, dataSize);
        end
    end

    task automatic startProgram();
        for (int i = 0; i < 256; i++) begin
            mem.imem[i] = '0;
            mem.dmem[i] = '0;
            dataModel[i] = '0;
        end
        for (int i = 0; i < 32; i++) begin
            model[i] = '0;
        end
        progLen = 0;
        expRegs.delete();
        expVals.delete();
        expPcs.delete();
        storedAddrs.delete();
    endtask

    task automatic writeInstr(input logic [W-1:0] word);
        mem.imem[progLen] = word;
        progLen++;
    endtask

    // Register write of the instruction emitted last
    task automatic expectWrite(input logic [4:0] rd, input logic [W-1:0] value);
        if (rd != 5'd0) begin
            model[rd] = value;
            expRegs.push_back(rd);
            expVals.push_back(value);
            expPcs.push_back(pcOf(progLen - 1));
        end
    endtask

    // Operands in assembly order rd, rs, rt
    task automatic rtypeOp(input logic [5:0] funct, input logic [4:0] rd,
                           input logic [4:0] rs, input logic [4:0] rt);
        logic [W-1:0] a;
        logic [W-1:0] b;
        logic [W-1:0] result;
        a = model[rs];
        b = model[rt];
        case (funct)
            isaPkg::fnAddu: result = a + b;
            isaPkg::fnSubu: result = a - b;
            isaPkg::fnAnd: result = a & b;
            isaPkg::fnOr: result = a | b;
            default: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        endcase
        writeInstr(rFormat(funct, rd, rs, rt));
        expectWrite(rd, result);
    endtask

    // Operands in assembly order rt, rs, imm
    task automatic immOp(input logic [5:0] op, input logic [4:0] rt,
                         input logic [4:0] rs, input logic [15:0] imm);
        logic [W-1:0] result;
        case (op)
            isaPkg::opAddiu: result = model[rs] + {{16{imm[15]}}, imm};
            isaPkg::opOri: result = model[rs] | {16'h0000, imm};
            default: result = {imm, 16'h0000};
        endcase
        writeInstr(iFormat(op, rs, rt, imm));
        expectWrite(rt, result);
    endtask

    task automatic storeWord(input logic [4:0] rt, input logic [4:0] base,
                             input logic [15:0] offset);
        logic [W-1:0] addr;
        addr = model[base] + {{16{offset[15]}}, offset};
        dataModel[addr[9:2]] = model[rt];
        storedAddrs.push_back(addr);
        writeInstr(iFormat(isaPkg::opSw, base, rt, offset));
    endtask

    task automatic loadWord(input logic [4:0] rt, input logic [4:0] base,
                            input logic [15:0] offset);
        logic [W-1:0] addr;
        addr = model[base] + {{16{offset[15]}}, offset};
        writeInstr(iFormat(isaPkg::opLw, base, rt, offset));
        expectWrite(rt, dataModel[addr[9:2]]);
    endtask

    task automatic resetCore();
        @(negedge clk);
        reset = 1'b1;
        repeat (2) @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic collectTrace(input string name);
        integer waited;
        for (int k = 0; k < expRegs.size(); k++) begin
            waited = 0;
            @(negedge clk);
            while (debugWbRfWen == 4'b0000 && waited < timeoutCycles) begin
                @(negedge clk);
                waited++;
            end
            if (debugWbRfWen == 4'b0000) begin
                $display("%s: no writeback arrived for trace entry %0d", name, k);
                errorCount++;
                break;
            end
            checkValue(name, "write enable", 32'hf, debugWbRfWen);
            checkValue(name, "register", expRegs[k], debugWbRfWnum);
            checkValue(name, "value", expVals[k], debugWbRfWdata);
            checkValue(name, "pc", expPcs[k], debugWbPc);
        end
    endtask

    task automatic runProgram(input string name);
        resetCore();
        collectTrace(name);
    endtask

    task automatic checkQuiet();
        checkValue("reset", "write enable", 32'h0, debugWbRfWen);
        checkValue("reset", "data request", 32'h0, {dataRead, dataWrite});
    endtask

    task automatic testReset();
        integer waited;
        startProgram();
        @(negedge clk);
        reset = 1'b1;
        @(negedge clk);
        checkQuiet();
        @(negedge clk);
        checkQuiet();
        reset = 1'b0;
        @(negedge clk);
        checkQuiet();
        waited = 0;
        while (instRead !== 1'b1 && waited < timeoutCycles) begin
            @(negedge clk);
            waited++;
        end
        if (instRead !== 1'b1) begin
            $display("reset: instruction fetch never started after reset");
            errorCount++;
        end else begin
            checkValue("reset", "first fetch address", pipePkg::resetVector, instAddr);
        end
    endtask

    task automatic testArithmetic();
        startProgram();
        immOp(isaPkg::opOri, 5'd1, 5'd0, 16'h1234);
        immOp(isaPkg::opLui, 5'd2, 5'd0, 16'h8001);
        immOp(isaPkg::opAddiu, 5'd3, 5'd1, 16'hfffc);
        rtypeOp(isaPkg::fnAddu, 5'd4, 5'd2, 5'd3);
        rtypeOp(isaPkg::fnSubu, 5'd5, 5'd3, 5'd2);
        rtypeOp(isaPkg::fnAnd, 5'd6, 5'd4, 5'd1);
        rtypeOp(isaPkg::fnOr, 5'd7, 5'd2, 5'd1);
        rtypeOp(isaPkg::fnSlt, 5'd8, 5'd2, 5'd1);
        rtypeOp(isaPkg::fnSlt, 5'd9, 5'd1, 5'd2);
        // Sign versus zero extension of the same immediate
        immOp(isaPkg::opAddiu, 5'd10, 5'd0, 16'h8000);
        immOp(isaPkg::opOri, 5'd11, 5'd0, 16'h8000);
        runProgram("arithmetic");
    endtask

    task automatic testForwarding();
        startProgram();
        immOp(isaPkg::opAddiu, 5'd1, 5'd0, 16'd1);
        immOp(isaPkg::opAddiu, 5'd2, 5'd1, 16'd2);
        rtypeOp(isaPkg::fnAddu, 5'd3, 5'd2, 5'd1);
        immOp(isaPkg::opOri, 5'd4, 5'd0, 16'h0010);
        immOp(isaPkg::opOri, 5'd5, 5'd0, 16'h0020);
        rtypeOp(isaPkg::fnAddu, 5'd6, 5'd4, 5'd5);
        immOp(isaPkg::opOri, 5'd7, 5'd0, 16'h0007);
        immOp(isaPkg::opAddiu, 5'd8, 5'd0, 16'd1);
        immOp(isaPkg::opAddiu, 5'd9, 5'd0, 16'd2);
        rtypeOp(isaPkg::fnSubu, 5'd10, 5'd7, 5'd9);
        rtypeOp(isaPkg::fnOr, 5'd11, 5'd7, 5'd8);
        runProgram("forwarding");
    endtask

    task automatic testMemory();
        logic [W-1:0] addr;
        startProgram();
        immOp(isaPkg::opOri, 5'd1, 5'd0, 16'h0100);
        immOp(isaPkg::opLui, 5'd2, 5'd0, 16'h1234);
        immOp(isaPkg::opOri, 5'd2, 5'd2, 16'h5678);
        storeWord(5'd2, 5'd1, 16'd0);
        immOp(isaPkg::opAddiu, 5'd3, 5'd0, 16'hfff9);
        storeWord(5'd3, 5'd1, 16'd4);
        loadWord(5'd4, 5'd1, 16'd0);
        loadWord(5'd5, 5'd1, 16'd4);
        rtypeOp(isaPkg::fnAddu, 5'd6, 5'd4, 5'd5);
        loadWord(5'd7, 5'd1, 16'd0);
        storeWord(5'd7, 5'd1, 16'd8);
        loadWord(5'd8, 5'd1, 16'd8);
        runProgram("memory");
        for (int i = 0; i < storedAddrs.size(); i++) begin
            addr = storedAddrs[i];
            checkValue("memory", "stored word", dataModel[addr[9:2]], mem.dmem[addr[9:2]]);
        end
    endtask

    task automatic testControlFlow();
        startProgram();
        immOp(isaPkg::opOri, 5'd1, 5'd0, 16'h0005);
        immOp(isaPkg::opOri, 5'd2, 5'd0, 16'h0005);
        // Taken beq to index 6
        writeInstr(iFormat(isaPkg::opBeq, 5'd1, 5'd2, 16'd3));
        immOp(isaPkg::opOri, 5'd3, 5'd0, 16'h0033);
        writeInstr(iFormat(isaPkg::opOri, 5'd0, 5'd4, 16'h0044));
        writeInstr(iFormat(isaPkg::opOri, 5'd0, 5'd5, 16'h0055));
        writeInstr(iFormat(isaPkg::opBne, 5'd1, 5'd2, 16'd2));
        immOp(isaPkg::opOri, 5'd6, 5'd0, 16'h0066);
        immOp(isaPkg::opOri, 5'd7, 5'd0, 16'h0077);
        // Jump to index 12
        writeInstr(jumpWord(pcOf(12)));
        immOp(isaPkg::opOri, 5'd8, 5'd0, 16'h0088);
        writeInstr(iFormat(isaPkg::opOri, 5'd0, 5'd9, 16'h0099));
        immOp(isaPkg::opOri, 5'd10, 5'd0, 16'h00aa);
        runProgram("control flow");
    endtask

    initial begin
        errorCount = 0;
        checkCount = 0;
        reset = 1'b1;
        testReset();
        testArithmetic();
        testForwarding();
        testMemory();
        testControlFlow();
        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
verilog/isaPkg.sv
verilog/pipePkg.sv
verilog/instructionDecoder.sv
verilog/registerFile.sv
verilog/operandForward.sv
verilog/fetchUnit.sv
verilog/pipelineCpu.sv
test/memoryModel.sv
test/cpuTb.sv
